// File: Bender.yml
package:
  name: pose_display

sources:
  # package first, then the leaf modules, then the top level
  - rtl/pose_pkg.sv
  - rtl/video_timing.sv
  - rtl/frame_pixel_source.sv
  - rtl/rgb_to_ycrcb.sv
  - rtl/mask_config.sv
  - rtl/chroma_threshold.sv
  - rtl/video_mux.sv
  - rtl/pose_display_top.sv
  - target: test
    files:
      - test/tb_pose_display.sv

// File: rtl/chroma_threshold.sv
`timescale 1ns/1ps

module chroma_threshold (
  input  logic                clk_pixel,
  input  logic                sys_rst_pixel,
  input  pose_pkg::ycrcb_t    ycrcb_i,
  input  pose_pkg::mask_cfg_t cfg_i,
  output logic                mask_o
);

  logic y_pass;
  logic cr_pass;
  logic cb_pass;

  // each channel passes at or above its cutoff
  assign y_pass  = (ycrcb_i.y >= cfg_i.y_cutoff);
  assign cr_pass = (ycrcb_i.cr >= cfg_i.cr_cutoff);
  assign cb_pass = (ycrcb_i.cb >= cfg_i.cb_cutoff);

  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      mask_o <= 1'b0;
    end else begin
      mask_o <= y_pass && cr_pass && cb_pass; // all three must agree
    end
  end

endmodule

// File: rtl/frame_pixel_source.sv
`timescale 1ns/1ps

module frame_pixel_source #(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720
) (
  input  logic              clk_pixel,
  input  logic              sys_rst_pixel,
  input  pose_pkg::timing_t timing_i,
  input  logic              pix_valid_i,
  input  pose_pkg::rgb565_t pix_data_i,
  input  logic              pix_last_i,
  output logic              pix_ready_o,
  output pose_pkg::rgb888_t pixel_o
);
  import pose_pkg::*;

  logic    last_pos;  // final active slot of the frame
  rgb565_t src_pixel;

  assign last_pos = (timing_i.hcount == HCOUNT_W'(H_ACTIVE - 1)) &&
                    (timing_i.vcount == VCOUNT_W'(V_ACTIVE - 1));

  // an end of frame word is held back until the raster reaches the last slot
  // otherwise one word is taken per active position
  assign pix_ready_o = pix_last_i ? last_pos : timing_i.active;

  // stream dry so show the fill colour instead
  assign src_pixel = pix_valid_i ? pix_data_i : FILL_PIXEL;

  // widen 565 to 888 with zero low bits
  always_ff @(posedge clk_pixel) begin
    pixel_o.red   <= {src_pixel.red, 3'b000};
    pixel_o.green <= {src_pixel.green, 2'b00};
    pixel_o.blue  <= {src_pixel.blue, 3'b000};
  end

  // the stream is only ever pulled inside the drawn area
  a_ready_in_active : assert property (
    @(posedge clk_pixel) disable iff (sys_rst_pixel)
    pix_ready_o |-> timing_i.active
  ) else $error("pix_ready_o high outside the active area");

endmodule

// File: rtl/mask_config.sv
`timescale 1ns/1ps

module mask_config (
  input  logic                clk_pixel,
  input  logic                sys_rst_pixel,
  input  logic [15:0]         sw_i,
  output pose_pkg::mask_cfg_t cfg_o
);
  import pose_pkg::*;

  mask_cfg_t cfg_d;

  // switch fields scattered over the word
  always_comb begin
    cfg_d.cr_cutoff    = {sw_i[11:8], 4'b0000};
    cfg_d.cb_cutoff    = {sw_i[15:12], 4'b0000};
    cfg_d.y_cutoff     = {sw_i[7:6], sw_i[3:1], 3'b000}; // bit 0 not part of y
    cfg_d.display_mode = display_mode_e'(sw_i[5:4]);
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      cfg_o <= '0; // camera view with open cutoffs
    end else begin
      cfg_o <= cfg_d;
    end
  end

endmodule

// File: rtl/pose_display_top.sv
`timescale 1ns/1ps

module pose_display_top #(
  parameter int H_ACTIVE = 1280,
  parameter int H_FRONT  = 110,
  parameter int H_SYNC   = 40,
  parameter int H_BACK   = 220,
  parameter int V_ACTIVE = 720,
  parameter int V_FRONT  = 5,
  parameter int V_SYNC   = 5,
  parameter int V_BACK   = 20
) (
  input  logic              clk_pixel,
  input  logic              sys_rst_pixel,
  input  logic              pix_valid_i,
  input  pose_pkg::rgb565_t pix_data_i,
  input  logic              pix_last_i,
  output logic              pix_ready_o,
  input  logic [15:0]       sw_i,
  output pose_pkg::rgb888_t rgb_o,
  output logic              hsync_o,
  output logic              vsync_o,
  output logic              active_o,
  output logic              new_frame_o
);
  import pose_pkg::*;

  timing_t   timing;      // raster position for the whole pipe
  mask_cfg_t cfg;         // cutoffs and view mode
  rgb888_t   cam_pixel;   // expanded camera colour
  ycrcb_t    cam_ycrcb;
  logic      mask;

  video_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) video_timing_i (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .timing_o      (timing)
  );

  frame_pixel_source #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
  ) frame_pixel_source_i (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .timing_i      (timing),
    .pix_valid_i   (pix_valid_i),
    .pix_data_i    (pix_data_i),
    .pix_last_i    (pix_last_i),
    .pix_ready_o   (pix_ready_o),
    .pixel_o       (cam_pixel)
  );

  rgb_to_ycrcb rgb_to_ycrcb_i (
    .clk_pixel (clk_pixel),
    .pixel_i   (cam_pixel),
    .ycrcb_o   (cam_ycrcb)
  );

  mask_config mask_config_i (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .sw_i          (sw_i),
    .cfg_o         (cfg)
  );

  chroma_threshold chroma_threshold_i (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .ycrcb_i       (cam_ycrcb),
    .cfg_i         (cfg),
    .mask_o        (mask)
  );

  video_mux video_mux_i (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .timing_i      (timing),
    .pixel_i       (cam_pixel),
    .mask_i        (mask),
    .cfg_i         (cfg),
    .rgb_o         (rgb_o),
    .hsync_o       (hsync_o),
    .vsync_o       (vsync_o),
    .active_o      (active_o),
    .new_frame_o   (new_frame_o)
  );

endmodule

// File: rtl/pose_pkg.sv
package pose_pkg;

  // counter widths sized for a 720p raster
  localparam int HCOUNT_W = 11;
  localparam int VCOUNT_W = 10;

  // camera stream word as it arrives
  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb888_t;

  // cr and cb carry a +128 offset so zero chroma sits mid scale
  typedef struct packed {
    logic [7:0] y;
    logic [7:0] cr;
    logic [7:0] cb;
  } ycrcb_t;

  typedef struct packed {
    logic [HCOUNT_W-1:0] hcount;
    logic [VCOUNT_W-1:0] vcount;
    logic                hsync;
    logic                vsync;
    logic                active;    // inside the drawn area
    logic                new_frame; // single cycle at 0,0
  } timing_t;

  typedef enum logic [1:0] {
    MODE_CAMERA  = 2'b00,
    MODE_BLANK   = 2'b01,
    MODE_MASK    = 2'b10,
    MODE_OVERLAY = 2'b11
  } display_mode_e;

  typedef struct packed {
    logic [7:0]    y_cutoff;
    logic [7:0]    cr_cutoff;
    logic [7:0]    cb_cutoff;
    display_mode_e display_mode;
  } mask_cfg_t;

  localparam int CONVERT_LATENCY = 3; // stages inside rgb_to_ycrcb
  localparam int PIPE_DEPTH = 6;      // timing position to output colour

  localparam rgb565_t FILL_PIXEL = 16'h2277; // shown when the stream runs dry
  localparam rgb888_t OVERLAY_COLOUR = 24'hff00ff; // magenta over masked pixels

endpackage

// File: rtl/rgb_to_ycrcb.sv
`timescale 1ns/1ps

module rgb_to_ycrcb (
  input  logic              clk_pixel,
  input  pose_pkg::rgb888_t pixel_i,
  output pose_pkg::ycrcb_t  ycrcb_o
);

  // bt.601 studio swing coefficients scaled by 1024
  localparam logic signed [19:0] K_Y_R  = 20'sd263;
  localparam logic signed [19:0] K_Y_G  = 20'sd516;
  localparam logic signed [19:0] K_Y_B  = 20'sd100;
  localparam logic signed [19:0] K_CR_R = 20'sd450;
  localparam logic signed [19:0] K_CR_G = -20'sd377;
  localparam logic signed [19:0] K_CR_B = -20'sd73;
  localparam logic signed [19:0] K_CB_R = -20'sd152;
  localparam logic signed [19:0] K_CB_G = -20'sd298;
  localparam logic signed [19:0] K_CB_B = 20'sd450;
  localparam logic [7:0] LUMA_OFFSET = 8'd16;

  logic signed [19:0] r_s, g_s, b_s;
  logic signed [19:0] prod_y_q  [3];
  logic signed [19:0] prod_cr_q [3];
  logic signed [19:0] prod_cb_q [3];
  logic signed [19:0] sum_y_q, sum_cr_q, sum_cb_q;

  // channels as positive signed operands
  assign r_s = $signed({12'd0, pixel_i.red});
  assign g_s = $signed({12'd0, pixel_i.green});
  assign b_s = $signed({12'd0, pixel_i.blue});

  // stage one products
  always_ff @(posedge clk_pixel) begin
    prod_y_q[0]  <= r_s * K_Y_R;
    prod_y_q[1]  <= g_s * K_Y_G;
    prod_y_q[2]  <= b_s * K_Y_B;
    prod_cr_q[0] <= r_s * K_CR_R;
    prod_cr_q[1] <= g_s * K_CR_G;
    prod_cr_q[2] <= b_s * K_CR_B;
    prod_cb_q[0] <= r_s * K_CB_R;
    prod_cb_q[1] <= g_s * K_CB_G;
    prod_cb_q[2] <= b_s * K_CB_B;
  end

  // stage two sums
  always_ff @(posedge clk_pixel) begin
    sum_y_q  <= prod_y_q[0] + prod_y_q[1] + prod_y_q[2];
    sum_cr_q <= prod_cr_q[0] + prod_cr_q[1] + prod_cr_q[2];
    sum_cb_q <= prod_cb_q[0] + prod_cb_q[1] + prod_cb_q[2];
  end

  // stage three drops the 1024 scale
  // flipping the sign bit maps signed chroma onto 0..255
  always_ff @(posedge clk_pixel) begin
    ycrcb_o.y  <= sum_y_q[17:10] + LUMA_OFFSET;  // luma tops out near 234
    ycrcb_o.cr <= {~sum_cr_q[17], sum_cr_q[16:10]};
    ycrcb_o.cb <= {~sum_cb_q[17], sum_cb_q[16:10]};
  end

endmodule

// File: rtl/video_mux.sv
`timescale 1ns/1ps

module video_mux (
  input  logic                clk_pixel,
  input  logic                sys_rst_pixel,
  input  pose_pkg::timing_t   timing_i,
  input  pose_pkg::rgb888_t   pixel_i,
  input  logic                mask_i,
  input  pose_pkg::mask_cfg_t cfg_i,
  output pose_pkg::rgb888_t   rgb_o,
  output logic                hsync_o,
  output logic                vsync_o,
  output logic                active_o,
  output logic                new_frame_o
);
  import pose_pkg::*;

  // timing waits for the whole pipe minus this stage
  // colour arrives one cycle late and skips the converter and threshold
  localparam int TIMING_DELAY = PIPE_DEPTH - 1;
  localparam int PIXEL_DELAY  = CONVERT_LATENCY + 1;

  timing_t timing_dly_q [TIMING_DELAY];
  rgb888_t pixel_dly_q  [PIXEL_DELAY];
  timing_t timing_now;  // lined up with mask_i
  rgb888_t pixel_now;
  rgb888_t colour_d;

  assign timing_now = timing_dly_q[TIMING_DELAY-1];
  assign pixel_now  = pixel_dly_q[PIXEL_DELAY-1];

  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      for (int i = 0; i < TIMING_DELAY; i++) begin
        timing_dly_q[i] <= '0;
      end
    end else begin
      timing_dly_q[0] <= timing_i;
      for (int i = 1; i < TIMING_DELAY; i++) begin
        timing_dly_q[i] <= timing_dly_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_pixel) begin
    pixel_dly_q[0] <= pixel_i;
    for (int i = 1; i < PIXEL_DELAY; i++) begin
      pixel_dly_q[i] <= pixel_dly_q[i-1];
    end
  end

  // mode select and blanking
  always_comb begin
    case (cfg_i.display_mode)
      MODE_CAMERA:  colour_d = pixel_now;
      MODE_BLANK:   colour_d = '0;
      MODE_MASK:    colour_d = mask_i ? 24'hffffff : 24'h000000;
      MODE_OVERLAY: colour_d = mask_i ? OVERLAY_COLOUR : pixel_now;
      default:      colour_d = '0;
    endcase
    if (!timing_now.active) begin
      colour_d = '0; // black in the porches and sync
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      rgb_o       <= '0;
      hsync_o     <= 1'b0;
      vsync_o     <= 1'b0;
      active_o    <= 1'b0;
      new_frame_o <= 1'b0;
    end else begin
      rgb_o       <= colour_d;
      hsync_o     <= timing_now.hsync;
      vsync_o     <= timing_now.vsync;
      active_o    <= timing_now.active;
      new_frame_o <= timing_now.new_frame;
    end
  end

  // frame start still lands on a drawn pixel after the delay lines
  a_new_frame_active : assert property (
    @(posedge clk_pixel) disable iff (sys_rst_pixel)
    new_frame_o |-> active_o
  ) else $error("new_frame_o outside the active area");

endmodule

// File: rtl/video_timing.sv
`timescale 1ns/1ps

module video_timing #(
  parameter int H_ACTIVE = 1280,
  parameter int H_FRONT  = 110,
  parameter int H_SYNC   = 40,
  parameter int H_BACK   = 220,
  parameter int V_ACTIVE = 720,
  parameter int V_FRONT  = 5,
  parameter int V_SYNC   = 5,
  parameter int V_BACK   = 20
) (
  input  logic              clk_pixel,
  input  logic              sys_rst_pixel,
  output pose_pkg::timing_t timing_o
);
  import pose_pkg::*;

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

  logic [HCOUNT_W-1:0] hcount_q;
  logic [VCOUNT_W-1:0] vcount_q;
  logic                line_end;
  logic                frame_end;

  assign line_end  = (hcount_q == HCOUNT_W'(H_TOTAL - 1));
  assign frame_end = (vcount_q == VCOUNT_W'(V_TOTAL - 1));

  // raster position counters
  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      hcount_q <= '0;
      vcount_q <= '0;
    end else if (line_end) begin
      hcount_q <= '0;
      vcount_q <= frame_end ? '0 : vcount_q + 1'b1; // wrap at bottom of frame
    end else begin
      hcount_q <= hcount_q + 1'b1;
    end
  end

  // flags decoded from the counters and registered alongside them
  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      timing_o <= '0; // nothing active until the first position
    end else begin
      timing_o.hcount <= hcount_q;
      timing_o.vcount <= vcount_q;
      timing_o.hsync  <= (hcount_q >= HCOUNT_W'(H_SYNC_START)) &&
                         (hcount_q < HCOUNT_W'(H_SYNC_START + H_SYNC));
      timing_o.vsync  <= (vcount_q >= VCOUNT_W'(V_SYNC_START)) &&
                         (vcount_q < VCOUNT_W'(V_SYNC_START + V_SYNC));
      timing_o.active <= (hcount_q < HCOUNT_W'(H_ACTIVE)) &&
                         (vcount_q < VCOUNT_W'(V_ACTIVE));
      timing_o.new_frame <= (hcount_q == '0) && (vcount_q == '0);
    end
  end

  // position never leaves the line
  a_hcount_in_line : assert property (
    @(posedge clk_pixel) disable iff (sys_rst_pixel)
    timing_o.hcount < HCOUNT_W'(H_TOTAL)
  ) else $error("hcount ran past the end of the line");

endmodule

// File: sim.f
rtl/pose_pkg.sv
rtl/video_timing.sv
rtl/frame_pixel_source.sv
rtl/rgb_to_ycrcb.sv
rtl/mask_config.sv
rtl/chroma_threshold.sv
rtl/video_mux.sv
rtl/pose_display_top.sv
test/tb_pose_display.sv

// File: test/mask_stimulus.mem
// columns: switch word, rgb565 pixel, valid flag, expected rgb888 output
// each line is held for one whole frame
0000 f800 1 f80000
0000 07e0 1 00fc00
0000 1234 1 1044a0
0000 0000 0 204cb8
0010 ffff 1 000000
0c20 f800 1 ffffff
0c20 001f 1 000000
c020 001f 1 ffffff
c020 f800 1 000000
00e2 ffff 1 ffffff
00e2 07e0 1 000000
8824 0000 1 ffffff
0c30 f800 1 ff00ff
0c30 001f 1 0000f8
b030 0000 0 ff00ff

// File: test/tb_pose_display.sv
`timescale 1ns/1ps

module tb_pose_display;
  import pose_pkg::*;

  // small raster so each frame is only a few hundred cycles
  localparam int H_ACTIVE = 16;
  localparam int H_FRONT  = 2;
  localparam int H_SYNC   = 3;
  localparam int H_BACK   = 3;
  localparam int V_ACTIVE = 8;
  localparam int V_FRONT  = 1;
  localparam int V_SYNC   = 1;
  localparam int V_BACK   = 2;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int FRAME_CYCLES  = H_TOTAL * V_TOTAL;
  localparam int ACTIVE_CYCLES = H_ACTIVE * V_ACTIVE;
  // ready follows the raster, which runs PIPE_DEPTH cycles ahead of new_frame_o
  localparam int LAST_READY_OFFSET = (V_ACTIVE - 1) * H_TOTAL + (H_ACTIVE - 1) - PIPE_DEPTH;
  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DELAY = 2;             // inputs change just after the edge
  localparam int WAIT_LIMIT  = 2 * FRAME_CYCLES;
  localparam int NUM_TESTS   = 15;
  localparam int FIELDS      = 4;             // switches, pixel, valid, expected colour

  logic        clk_pixel;
  logic        sys_rst_pixel;
  logic        pix_valid;
  rgb565_t     pix_data;
  logic        pix_last;
  logic        pix_ready;
  logic [15:0] sw;
  rgb888_t     rgb;
  logic        hsync;
  logic        vsync;
  logic        active;
  logic        new_frame;

  logic [23:0] stim_mem [FIELDS*NUM_TESTS]; // one line of the data file per FIELDS words
  int          error_count;
  int          check_count;

  pose_display_top #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) pose_display_top_i (
    .clk_pixel     (clk_pixel),
    .sys_rst_pixel (sys_rst_pixel),
    .pix_valid_i   (pix_valid),
    .pix_data_i    (pix_data),
    .pix_last_i    (pix_last),
    .pix_ready_o   (pix_ready),
    .sw_i          (sw),
    .rgb_o         (rgb),
    .hsync_o       (hsync),
    .vsync_o       (vsync),
    .active_o      (active),
    .new_frame_o   (new_frame)
  );

  initial begin
    clk_pixel = 1'b0;
    forever #(CLK_PERIOD / 2) clk_pixel = ~clk_pixel;
  end

  // 565 to 888 by moving each field to the top of its byte
  function automatic rgb888_t expand_rgb565(input rgb565_t p);
    rgb888_t c;
    c.red   = {p.red, 3'b000};
    c.green = {p.green, 2'b00};
    c.blue  = {p.blue, 3'b000};
    return c;
  endfunction

  task automatic log_mismatch(input string msg);
    error_count++;
    $display("CHECK FAILED at %0d ns: %s", $time, msg);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic drive_inputs(input logic [15:0] sw_word, input rgb565_t pixel,
                              input logic valid, input logic last);
    @(posedge clk_pixel);
    #DRIVE_DELAY;
    sw        = sw_word;
    pix_data  = pixel;
    pix_valid = valid;
    pix_last  = last;
  endtask

  // steps at least one cycle so a frame start already seen is skipped
  task automatic wait_frame_start();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk_pixel);
      cycles++;
    end while (!new_frame && cycles < WAIT_LIMIT);
    if (!new_frame) begin
      abort_run($sformatf("timed out: no frame start within %0d cycles", WAIT_LIMIT));
    end
  endtask

  // first edge after release loads position 0,0 into the raster
  task automatic verify_reset_quiet();
    @(posedge clk_pixel);
    for (int i = 0; i < PIPE_DEPTH; i++) begin
      @(negedge clk_pixel);
      check_count++;
      assert (!active && !hsync && !vsync && !new_frame) else begin
        log_mismatch($sformatf("outputs not quiet %0d cycles into pipeline fill", i));
      end
    end
    @(negedge clk_pixel);
    check_count++;
    assert (active && new_frame) else begin
      log_mismatch("first frame start missing after the pipeline depth");
    end
  endtask

  // one whole frame sampled from its new_frame_o cycle onward
  task automatic check_frame(input int line_no, input rgb888_t expected);
    int active_cycles;
    int frame_pulses;
    int ready_cycles;
    int hsync_cycles;
    int vsync_cycles;
    active_cycles = 0;
    frame_pulses  = 0;
    ready_cycles  = 0;
    hsync_cycles  = 0;
    vsync_cycles  = 0;
    for (int k = 0; k < FRAME_CYCLES; k++) begin
      check_count++;
      if (active) begin
        active_cycles++;
        assert (rgb == expected) else begin
          log_mismatch($sformatf("line %0d: rgb_o %06h, expected %06h",
                                 line_no, rgb, expected));
        end
      end else begin
        assert (rgb == 24'h000000) else begin
          log_mismatch($sformatf("line %0d: rgb_o %06h outside active, expected black",
                                 line_no, rgb));
        end
      end
      frame_pulses += new_frame;
      ready_cycles += pix_ready;
      hsync_cycles += hsync;
      vsync_cycles += vsync;
      @(negedge clk_pixel);
    end
    check_count += 5;
    assert (active_cycles == ACTIVE_CYCLES) else begin
      log_mismatch($sformatf("line %0d: %0d active cycles in frame", line_no, active_cycles));
    end
    assert (frame_pulses == 1) else begin
      log_mismatch($sformatf("line %0d: %0d new_frame pulses in frame", line_no, frame_pulses));
    end
    assert (ready_cycles == ACTIVE_CYCLES) else begin
      log_mismatch($sformatf("line %0d: %0d ready cycles in frame", line_no, ready_cycles));
    end
    assert (hsync_cycles == H_SYNC * V_TOTAL) else begin
      log_mismatch($sformatf("line %0d: %0d hsync cycles in frame", line_no, hsync_cycles));
    end
    assert (vsync_cycles == V_SYNC * H_TOTAL) else begin
      log_mismatch($sformatf("line %0d: %0d vsync cycles in frame", line_no, vsync_cycles));
    end
  endtask

  task automatic run_stimulus_line(input int t);
    logic [15:0] sw_word;
    rgb565_t     pixel;
    logic        valid;
    rgb888_t     expected;
    rgb888_t     model;
    sw_word  = stim_mem[FIELDS*t][15:0];
    pixel    = stim_mem[FIELDS*t+1][15:0];
    valid    = stim_mem[FIELDS*t+2][0];
    expected = stim_mem[FIELDS*t+3];
    // camera view is the widened stream word, or the fill colour when dry
    if (sw_word[5:4] == MODE_CAMERA) begin
      model = expand_rgb565(valid ? pixel : FILL_PIXEL);
      check_count++;
      assert (model == expected) else begin
        log_mismatch($sformatf("line %0d: file colour %06h, expansion gives %06h",
                               t, expected, model));
      end
    end
    drive_inputs(sw_word, pixel, valid, 1'b0);
    repeat (2) wait_frame_start(); // a full frame on the new switches first
    check_frame(t, expected);
  endtask

  // end of frame word waits for the last active slot
  task automatic verify_ready_at_last();
    drive_inputs(16'h0000, 16'hffff, 1'b1, 1'b1);
    repeat (2) wait_frame_start();
    for (int k = 0; k < FRAME_CYCLES; k++) begin
      check_count++;
      assert (pix_ready == (k == LAST_READY_OFFSET)) else begin
        log_mismatch($sformatf("last held: pix_ready_o %b at frame offset %0d", pix_ready, k));
      end
      @(negedge clk_pixel);
    end
  endtask

  initial begin
    sys_rst_pixel = 1'b1;
    pix_valid     = 1'b0;
    pix_data      = '0;
    pix_last      = 1'b0;
    sw            = '0;
    error_count   = 0;
    check_count   = 0;
    $readmemh("test/mask_stimulus.mem", stim_mem);
    if ($isunknown(stim_mem[FIELDS*NUM_TESTS-1])) begin
      abort_run("stimulus file test/mask_stimulus.mem is missing or too short");
    end
    repeat (3) @(posedge clk_pixel);
    #DRIVE_DELAY;
    sys_rst_pixel = 1'b0;
    verify_reset_quiet();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_stimulus_line(t);
    end
    verify_ready_at_last();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
